// File: all.f
src/trc_pkg.sv
src/trace_align.sv
src/trace_fifo.sv
src/trace_port.sv
src/trace_top.sv
sim/trace_chk.sv
sim/trace_tb.sv

// File: sim/trace_tb.sv
`timescale 1ns/1ps

module trace_tb;

    ////////////////////////////////////////////////////////////
    // DUT signals and testbench state
    ////////////////////////////////////////////////////////////

    localparam int N_INS = 256;  // instruction table size
    // rough cycle cost per test: reset, plain, wb, ls, stall, overflow, random
    localparam int RUN_CYCLES = 10 + 12 + 15 + 12 + 40 + 75 + 55;
    localparam int CYC_LIMIT  = 2 * RUN_CYCLES;  // generous margin

    logic tcb_ifu, rst_n;
    logic ifu_vld, ifu_rdy, lsu_vld, lsu_rdy, lsu_wen, gpr_den, trc_crd;
    trc_pkg::xlen_t ifu_adr, ifu_rdt, lsu_adr, lsu_wdt, lsu_rdt, gpr_ddt;
    trc_pkg::lsu_siz_t   lsu_siz;
    trc_pkg::gpr_idx_t   gpr_did;
    logic                trc_vld, overflow;
    trc_pkg::trace_rec_t trc_rec;

    // instruction table, one entry per fetch
    trc_pkg::xlen_t    i_pc [N_INS], i_ins [N_INS], i_adr [N_INS];
    trc_pkg::xlen_t    i_wdt [N_INS], i_rdt [N_INS], i_ddt [N_INS];
    logic              i_ls [N_INS], i_wen [N_INS], i_wb [N_INS];
    trc_pkg::lsu_siz_t i_siz [N_INS];
    trc_pkg::gpr_idx_t i_idx [N_INS];
    int n_ins = 0;
    int s1 = -1, s2 = -1;        // table index one and two cycles after fetch

    trc_pkg::trace_rec_t exp_q[$], rx_q[$];
    int errors = 0, checks = 0, cyc = 0, owed = 0;
    bit crd_hold = 0;            // receiver withholds credits
    logic [31:0] rng = 32'h3c48;

    trace_top DUT (.*);

    always #4 tcb_ifu = ~tcb_ifu;  // 8 ns period

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic int add_ins(trc_pkg::xlen_t pc, trc_pkg::xlen_t ins, logic ls,
            logic wen, trc_pkg::lsu_siz_t siz, trc_pkg::xlen_t adr, trc_pkg::xlen_t wdt,
            trc_pkg::xlen_t rdt, logic wb, trc_pkg::gpr_idx_t idx, trc_pkg::xlen_t ddt);
        i_pc[n_ins]  = pc;
        i_ins[n_ins] = ins;
        i_ls[n_ins]  = ls;
        i_wen[n_ins] = wen;
        i_siz[n_ins] = siz;
        i_adr[n_ins] = adr;
        i_wdt[n_ins] = wdt;
        i_rdt[n_ins] = rdt;
        i_wb[n_ins]  = wb;
        i_idx[n_ins] = idx;
        i_ddt[n_ins] = ddt;
        n_ins++;
        return n_ins - 1;
    endfunction

    // expected record from the field layout, unused fields zero
    function automatic trc_pkg::trace_rec_t build_rec(int k);
        trc_pkg::trace_rec_t r;
        r = '0;
        r[trc_pkg::OFS_PC  +: 32] = i_pc[k];
        r[trc_pkg::OFS_INS +: 32] = i_ins[k];
        r[trc_pkg::OFS_INS32]     = (i_ins[k][1:0] == 2'b11);
        if (i_wb[k]) begin
            r[trc_pkg::OFS_WB_EN]       = 1'b1;
            r[trc_pkg::OFS_WB_IDX +: 5]  = i_idx[k];
            r[trc_pkg::OFS_WB_DAT +: 32] = i_ddt[k];
        end
        if (i_ls[k]) begin
            r[trc_pkg::OFS_LS_EN]        = 1'b1;
            r[trc_pkg::OFS_LS_WEN]       = i_wen[k];
            r[trc_pkg::OFS_LS_SIZ +: 2]  = i_siz[k];
            r[trc_pkg::OFS_LS_ADR +: 32] = i_adr[k];
            r[trc_pkg::OFS_LS_DAT +: 32] = i_wen[k] ? i_wdt[k] : i_rdt[k];
        end
        return r;
    endfunction

    // one bus cycle: new fetch k (-1 idle), stall = vld without rdy
    task automatic step(input int k, input bit stall);
        @(negedge tcb_ifu);
        ifu_vld = (k >= 0) || stall;
        ifu_rdy = (k >= 0);
        ifu_adr = (k >= 0) ? i_pc[k] : (stall ? next_rand() : '0);
        ifu_rdt = (s1 >= 0) ? i_ins[s1] : '0;      // response phase
        lsu_vld = (s1 >= 0) && i_ls[s1];          // ls one cycle behind fetch
        lsu_rdy = lsu_vld;
        lsu_wen = (s1 >= 0) && i_wen[s1];
        lsu_siz = (s1 >= 0) ? i_siz[s1] : '0;
        lsu_adr = (s1 >= 0) ? i_adr[s1] : '0;
        lsu_wdt = (s1 >= 0) ? i_wdt[s1] : '0;
        lsu_rdt = (s2 >= 0) ? i_rdt[s2] : '0;     // load data two cycles behind
        gpr_den = (s2 >= 0) && i_wb[s2];
        gpr_did = (s2 >= 0) ? i_idx[s2] : '0;
        gpr_ddt = (s2 >= 0) ? i_ddt[s2] : '0;
        s2 = s1;
        s1 = k;
    endtask

    task automatic drain();
        repeat (3) step(-1, 1'b0);
    endtask

    task automatic wait_rx(input int n);
        while (rx_q.size() < n) @(posedge tcb_ifu);
    endtask

    task automatic check_val(input string name, input trc_pkg::trace_rec_t got,
                             input trc_pkg::trace_rec_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compare_records();
        if (rx_q.size() != exp_q.size()) begin
            errors++;
            $display("wrong number of records: got %0d, expected %0d",
                     rx_q.size(), exp_q.size());
        end
        foreach (exp_q[i]) begin
            if (i < rx_q.size()) check_val("trc_rec", rx_q[i], exp_q[i]);
        end
        rx_q.delete();
        exp_q.delete();
    endtask

    ////////////////////////////////////////////////////////////
    // receiver model and timeout
    ////////////////////////////////////////////////////////////

    always @(negedge tcb_ifu) begin
        if (rst_n && trc_vld) begin
            rx_q.push_back(trc_rec);
            owed++;                    // credit due back
        end
        trc_crd = 1'b0;
        if (!crd_hold && owed > 0) begin
            trc_crd = 1'b1;            // one credit per cycle
            owed--;
        end
    end

    always @(posedge tcb_ifu) begin
        cyc++;
        if (cyc >= CYC_LIMIT) begin
            $display("timeout: run stopped after %0d cycles", cyc);
            $display("Testbench failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic plain_fetches();
        int k;
        // idle load/store and write ports carry junk that must not show up
        k = add_ins(32'h0000_1000, 32'h00a0_0093, 0, 1, 3, 32'h8000_00f0, 32'h5555_aaaa,
                    32'h3333_cccc, 0, 7, 32'h0f0f_0f0f);                     // addi
        exp_q.push_back(build_rec(k));
        step(k, 1'b0);
        step(-1, 1'b0);
        k = add_ins(32'h0000_1004, 32'h0000_4505, 0, 1, 2, 32'h8000_00f4, 32'h6666_9999,
                    32'h7777_8888, 0, 9, 32'hf0f0_f0f0);                     // c.li
        exp_q.push_back(build_rec(k));
        step(k, 1'b0);
        drain();
        wait_rx(exp_q.size());
        compare_records();
    endtask

    task automatic writeback_burst();
        int k;
        for (int j = 0; j < 6; j++) begin
            k = add_ins(32'h2000 + 4 * j, 32'h0010_0013 + (j << 7), 0, 0, 0, 0, 0, 0,
                        1, j + 1, 32'hd000_0000 + j);
            exp_q.push_back(build_rec(k));
            step(k, 1'b0);     // back to back
        end
        drain();
        wait_rx(exp_q.size());
        compare_records();
    endtask

    task automatic load_store();
        int k;
        k = add_ins(32'h3000, 32'h0005_2503, 1, 0, 2, 32'h8000_0010, 32'h0,
                    32'hcafe_f00d, 1, 10, 32'hcafe_f00d);                    // lw
        exp_q.push_back(build_rec(k));
        step(k, 1'b0);
        k = add_ins(32'h3004, 32'h00b5_0023, 1, 1, 0, 32'h8000_0021, 32'h0000_005a,
                    32'h1234_5678, 0, 0, 0);                                 // sb
        exp_q.push_back(build_rec(k));
        step(k, 1'b0);
        k = add_ins(32'h3008, 32'h0005_1583, 1, 0, 1, 32'h8000_0032, 32'h0,
                    32'h0000_beef, 1, 11, 32'hffff_beef);                    // lh
        exp_q.push_back(build_rec(k));
        step(k, 1'b0);
        drain();
        wait_rx(exp_q.size());
        compare_records();
    endtask

    task automatic credit_stall();
        int k;
        crd_hold = 1;
        for (int j = 0; j < 6; j++) begin
            k = add_ins(32'h4000 + 4 * j, next_rand() | 32'h3, 0, 0, 0, 0, 0, 0,
                        1, j + 3, next_rand());
            exp_q.push_back(build_rec(k));
            step(k, 1'b0);
        end
        drain();
        repeat (20) @(posedge tcb_ifu);
        if (rx_q.size() != trc_pkg::CREDITS) begin
            errors++;
            $display("credit stall let %0d records out instead of %0d",
                     rx_q.size(), trc_pkg::CREDITS);
        end
        crd_hold = 0;
        wait_rx(exp_q.size());
        // buffer had room, nothing dropped
        check_val("overflow", trc_pkg::trace_rec_t'(overflow), trc_pkg::trace_rec_t'(0));
        compare_records();
    endtask

    task automatic buffer_overflow();
        int k;
        while (owed > 0) @(posedge tcb_ifu);  // all credits back at the port first
        crd_hold = 1;
        for (int j = 0; j < trc_pkg::FIFO_DEPTH + trc_pkg::CREDITS + 3; j++) begin
            k = add_ins(32'h5000 + 4 * j, next_rand(), 0, 0, 0, 0, 0, 0, 0, 0, 0);
            if (j < trc_pkg::FIFO_DEPTH + trc_pkg::CREDITS) begin
                exp_q.push_back(build_rec(k));  // later ones are dropped
            end
            step(k, 1'b0);
        end
        drain();
        repeat (10) @(posedge tcb_ifu);
        check_val("overflow", trc_pkg::trace_rec_t'(overflow), trc_pkg::trace_rec_t'(1));
        crd_hold = 0;
        wait_rx(exp_q.size());
        repeat (30) @(posedge tcb_ifu);   // nothing more may arrive
        compare_records();
    endtask

    task automatic random_traffic();
        int k;
        logic [31:0] r;
        for (int j = 0; j < 40; j++) begin
            r = next_rand();
            if (r[2:0] == 3'd0) step(-1, 1'b1);   // fetch wait state
            k = add_ins(next_rand(), next_rand(), r[3], r[4], r[6:5], next_rand(),
                        next_rand(), next_rand(), r[7], r[12:8], next_rand());
            exp_q.push_back(build_rec(k));
            step(k, 1'b0);
        end
        drain();
        wait_rx(exp_q.size());
        compare_records();
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        tcb_ifu = 0;
        rst_n   = 0;
        {ifu_vld, ifu_rdy, lsu_vld, lsu_rdy, lsu_wen, gpr_den, trc_crd} = '0;
        {ifu_adr, ifu_rdt, lsu_adr, lsu_wdt, lsu_rdt, gpr_ddt} = '0;
        lsu_siz = '0;
        gpr_did = '0;
        repeat (10) @(negedge tcb_ifu);
        rst_n = 1;
        plain_fetches();
        writeback_burst();
        load_store();
        credit_stall();
        buffer_overflow();
        random_traffic();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: sim/trace_chk.sv
`timescale 1ns/1ps

module trace_chk (
    input logic tcb_ifu,
    input logic rst_n,
    input logic trc_vld,
    input logic trc_crd,
    input logic overflow
);

    // credits held as seen from the trace port pins
    logic [trc_pkg::CRD_W:0] crd_mdl;

    always_ff @(posedge tcb_ifu) begin
        if (!rst_n) begin
            crd_mdl <= (trc_pkg::CRD_W + 1)'(trc_pkg::CREDITS);
        end else begin
            crd_mdl <= crd_mdl + trc_crd - trc_vld;  // return minus send
        end
    end

    a_no_send_without_credit : assert property (@(posedge tcb_ifu) disable iff (!rst_n)
        trc_vld |-> crd_mdl != 0)
        else $error("trace record sent with no credit held");

    a_overflow_sticky : assert property (@(posedge tcb_ifu) disable iff (!rst_n)
        overflow |=> overflow)
        else $error("overflow flag cleared without reset");

    a_vld_low_after_reset : assert property (@(posedge tcb_ifu) !rst_n |=> !trc_vld)
        else $error("trc_vld high right after reset");

endmodule

bind trace_top trace_chk chk (.tcb_ifu, .rst_n, .trc_vld, .trc_crd, .overflow);

// File: src/trace_top.sv
`timescale 1ns/1ps

module trace_top (
    input  logic                tcb_ifu,     // clock
    input  logic                rst_n,
    // fetch bus
    input  logic                ifu_vld,
    input  logic                ifu_rdy,
    input  trc_pkg::xlen_t      ifu_adr,
    input  trc_pkg::xlen_t      ifu_rdt,
    // load/store bus
    input  logic                lsu_vld,
    input  logic                lsu_rdy,
    input  logic                lsu_wen,
    input  trc_pkg::xlen_t      lsu_adr,
    input  trc_pkg::lsu_siz_t   lsu_siz,
    input  trc_pkg::xlen_t      lsu_wdt,
    input  trc_pkg::xlen_t      lsu_rdt,
    // register write port
    input  logic                gpr_den,
    input  trc_pkg::gpr_idx_t   gpr_did,
    input  trc_pkg::xlen_t      gpr_ddt,
    // trace output
    input  logic                trc_crd,
    output logic                trc_vld,
    output trc_pkg::trace_rec_t trc_rec,
    output logic                overflow
);

    ////////////////////////////////////////////////////////////
    // internal links
    ////////////////////////////////////////////////////////////

    logic                rec_wr;         // monitor -> buffer
    trc_pkg::trace_rec_t rec_dat;
    logic                fifo_rd;        // port pops buffer
    trc_pkg::trace_rec_t fifo_dat;
    logic                fifo_nempty;

    trace_align u_align (
        .tcb_ifu, .rst_n,
        .ifu_vld, .ifu_rdy, .ifu_adr, .ifu_rdt,
        .lsu_vld, .lsu_rdy, .lsu_wen, .lsu_adr, .lsu_siz, .lsu_wdt, .lsu_rdt,
        .gpr_den, .gpr_did, .gpr_ddt,
        .rec_wr,  .rec_dat
    );

    trace_fifo u_fifo (
        .tcb_ifu, .rst_n,
        .rec_wr,  .rec_dat,
        .fifo_rd, .fifo_dat, .fifo_nempty, .overflow
    );

    trace_port u_port (
        .tcb_ifu, .rst_n,
        .fifo_dat, .fifo_nempty, .fifo_rd,
        .trc_crd,  .trc_vld,     .trc_rec
    );

endmodule

// File: src/trace_port.sv
`timescale 1ns/1ps

module trace_port (
    input  logic                tcb_ifu,    // clock
    input  logic                rst_n,
    // buffer side
    input  trc_pkg::trace_rec_t fifo_dat,
    input  logic                fifo_nempty,
    output logic                fifo_rd,
    // trace output, credit flow control
    input  logic                trc_crd,    // one credit back per pulse
    output logic                trc_vld,
    output trc_pkg::trace_rec_t trc_rec
);

    ////////////////////////////////////////////////////////////
    // credit counter
    ////////////////////////////////////////////////////////////

    logic [trc_pkg::CRD_W-1:0] crd_cnt;
    logic                      crd_any;    // at least one credit held

    assign crd_any = (crd_cnt != '0);
    assign fifo_rd = fifo_nempty & crd_any;

    // credit spent at pop, the send follows one cycle later
    always_ff @(posedge tcb_ifu) begin
        if (!rst_n) begin
            crd_cnt <= trc_pkg::CRD_W'(trc_pkg::CREDITS);
        end else begin
            case ({trc_crd, fifo_rd})
                2'b10:   crd_cnt <= crd_cnt + 1'b1;
                2'b01:   crd_cnt <= crd_cnt - 1'b1;
                default: crd_cnt <= crd_cnt;   // return and spend cancel
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge tcb_ifu) begin
        if (!rst_n) begin
            trc_vld <= 1'b0;
        end else begin
            trc_vld <= fifo_rd;
        end
    end

    always_ff @(posedge tcb_ifu) begin
        if (fifo_rd) begin
            trc_rec <= fifo_dat;   // holds last record while idle
        end
    end

endmodule

// File: src/trace_fifo.sv
`timescale 1ns/1ps

module trace_fifo (
    input  logic                tcb_ifu,      // clock
    input  logic                rst_n,
    // write side, from monitor
    input  logic                rec_wr,
    input  trc_pkg::trace_rec_t rec_dat,
    // read side, toward port
    input  logic                fifo_rd,
    output trc_pkg::trace_rec_t fifo_dat,
    output logic                fifo_nempty,
    output logic                overflow      // sticky until reset
);

    ////////////////////////////////////////////////////////////
    // storage and pointers
    ////////////////////////////////////////////////////////////

    trc_pkg::trace_rec_t        mem [trc_pkg::FIFO_DEPTH];

    logic [trc_pkg::FIFO_AW-1:0] wr_ptr;
    logic [trc_pkg::FIFO_AW-1:0] rd_ptr;
    logic [trc_pkg::FIFO_AW:0]   cnt;         // occupancy, one extra bit for full

    logic full;
    logic wr_ok;                              // accepted write
    logic rd_ok;                              // accepted read

    assign full  = (cnt == trc_pkg::FIFO_DEPTH);
    assign wr_ok = rec_wr & ~full;            // never stall the core, drop instead
    assign rd_ok = fifo_rd & fifo_nempty;

    always_ff @(posedge tcb_ifu) begin
        if (wr_ok) begin
            mem[wr_ptr] <= rec_dat;
        end
    end

    ////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge tcb_ifu) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            cnt      <= '0;
            overflow <= 1'b0;
        end else begin
            if (wr_ok) wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            if (rd_ok) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_ok, rd_ok})
                2'b10:   cnt <= cnt + 1'b1;
                2'b01:   cnt <= cnt - 1'b1;
                default: cnt <= cnt;              // both or neither
            endcase
            if (rec_wr && full) begin
                overflow <= 1'b1;                 // record lost
            end
        end
    end

    assign fifo_dat    = mem[rd_ptr];  // head shown during pop
    assign fifo_nempty = (cnt != '0);

endmodule

// File: src/trace_align.sv
`timescale 1ns/1ps

module trace_align (
    input  logic                tcb_ifu,   // clock
    input  logic                rst_n,
    // fetch bus
    input  logic                ifu_vld,
    input  logic                ifu_rdy,
    input  trc_pkg::xlen_t      ifu_adr,
    input  trc_pkg::xlen_t      ifu_rdt,
    // load/store bus
    input  logic                lsu_vld,
    input  logic                lsu_rdy,
    input  logic                lsu_wen,
    input  trc_pkg::xlen_t      lsu_adr,
    input  trc_pkg::lsu_siz_t   lsu_siz,
    input  trc_pkg::xlen_t      lsu_wdt,
    input  trc_pkg::xlen_t      lsu_rdt,
    // register write port
    input  logic                gpr_den,
    input  trc_pkg::gpr_idx_t   gpr_did,
    input  trc_pkg::xlen_t      gpr_ddt,
    // record out
    output logic                rec_wr,
    output trc_pkg::trace_rec_t rec_dat
);

    ////////////////////////////////////////////////////////////
    // local signals
    ////////////////////////////////////////////////////////////

    logic              ifu_trn;    // fetch transfer this cycle
    logic              lsu_trn;    // load/store transfer this cycle

    // stage 1, cycle after fetch transfer
    logic              s1_vld;
    trc_pkg::xlen_t    s1_adr;     // pc

    // stage 2, two cycles after fetch transfer
    logic              s2_vld;
    trc_pkg::xlen_t    s2_adr;
    trc_pkg::xlen_t    s2_ins;
    logic              s2_ins32;
    logic              s2_ls_en;
    logic              s2_ls_wen;
    trc_pkg::lsu_siz_t s2_ls_siz;
    trc_pkg::xlen_t    s2_ls_adr;
    trc_pkg::xlen_t    s2_ls_wdt;  // store data, held for the record

    // qualified record fields
    trc_pkg::gpr_idx_t wb_idx;
    trc_pkg::xlen_t    wb_dat;
    trc_pkg::xlen_t    ls_dat;

    assign ifu_trn = ifu_vld & ifu_rdy;
    assign lsu_trn = lsu_vld & lsu_rdy;

    ////////////////////////////////////////////////////////////
    // valid chain
    ////////////////////////////////////////////////////////////

    always_ff @(posedge tcb_ifu) begin
        if (!rst_n) begin
            s1_vld   <= 1'b0;
            s2_vld   <= 1'b0;
            s2_ls_en <= 1'b0;
        end else begin
            s1_vld   <= ifu_trn;
            s2_vld   <= s1_vld;
            s2_ls_en <= s1_vld & lsu_trn;  // only a load/store behind a fetch
        end
    end

    ////////////////////////////////////////////////////////////
    // payload pipeline
    ////////////////////////////////////////////////////////////

    always_ff @(posedge tcb_ifu) begin
        s1_adr    <= ifu_adr;              // request phase address
        s2_adr    <= s1_adr;
        s2_ins    <= ifu_rdt;              // response phase, one cycle late
        s2_ins32  <= &ifu_rdt[1:0];        // 2'b11 marks a 32-bit encoding
        // load/store request sits one cycle behind the fetch
        s2_ls_wen <= lsu_wen;
        s2_ls_siz <= lsu_siz;
        s2_ls_adr <= lsu_adr;
        s2_ls_wdt <= lsu_wdt;
    end

    ////////////////////////////////////////////////////////////
    // record assembly
    ////////////////////////////////////////////////////////////

    // unused fields read as zero
    assign wb_idx = gpr_den ? gpr_did : '0;
    assign wb_dat = gpr_den ? gpr_ddt : '0;

    always_comb begin
        if (!s2_ls_en) begin
            ls_dat = '0;
        end else if (s2_ls_wen) begin
            ls_dat = s2_ls_wdt;            // store
        end else begin
            ls_dat = lsu_rdt;              // load data arrives now
        end
    end

    always_comb begin
        rec_dat = '0;
        rec_dat[trc_pkg::OFS_PC     +: trc_pkg::XLEN]  = s2_adr;
        rec_dat[trc_pkg::OFS_INS    +: trc_pkg::XLEN]  = s2_ins;
        rec_dat[trc_pkg::OFS_INS32]                    = s2_ins32;
        rec_dat[trc_pkg::OFS_WB_EN]                    = gpr_den;
        rec_dat[trc_pkg::OFS_WB_IDX +: trc_pkg::GPR_W] = wb_idx;
        rec_dat[trc_pkg::OFS_WB_DAT +: trc_pkg::XLEN]  = wb_dat;
        rec_dat[trc_pkg::OFS_LS_EN]                    = s2_ls_en;
        rec_dat[trc_pkg::OFS_LS_WEN]                   = s2_ls_en & s2_ls_wen;
        rec_dat[trc_pkg::OFS_LS_SIZ +: trc_pkg::SIZ_W] = s2_ls_en ? s2_ls_siz : '0;
        rec_dat[trc_pkg::OFS_LS_ADR +: trc_pkg::XLEN]  = s2_ls_en ? s2_ls_adr : '0;
        rec_dat[trc_pkg::OFS_LS_DAT +: trc_pkg::XLEN]  = ls_dat;
    end

    assign rec_wr = s2_vld;  // one record per fetch

endmodule

// File: src/trc_pkg.sv
package trc_pkg;

    ////////////////////////////////////////////////////////////
    // basic widths
    ////////////////////////////////////////////////////////////

    localparam int unsigned XLEN  = 32;  // address/data word
    localparam int unsigned GPR_W = 5;   // register index
    localparam int unsigned SIZ_W = 2;   // log2 access size

    typedef logic [XLEN-1:0]  xlen_t;
    typedef logic [GPR_W-1:0] gpr_idx_t;
    typedef logic [SIZ_W-1:0] lsu_siz_t;

    ////////////////////////////////////////////////////////////
    // record layout, packed from bit 0 upward
    ////////////////////////////////////////////////////////////

    localparam int unsigned OFS_LS_DAT = 0;                       // load or store data
    localparam int unsigned OFS_LS_ADR = OFS_LS_DAT + XLEN;
    localparam int unsigned OFS_LS_SIZ = OFS_LS_ADR + XLEN;
    localparam int unsigned OFS_LS_WEN = OFS_LS_SIZ + SIZ_W;      // 1 = store
    localparam int unsigned OFS_LS_EN  = OFS_LS_WEN + 1;
    localparam int unsigned OFS_WB_DAT = OFS_LS_EN + 1;
    localparam int unsigned OFS_WB_IDX = OFS_WB_DAT + XLEN;
    localparam int unsigned OFS_WB_EN  = OFS_WB_IDX + GPR_W;
    localparam int unsigned OFS_INS32  = OFS_WB_EN + 1;           // not compressed
    localparam int unsigned OFS_INS    = OFS_INS32 + 1;
    localparam int unsigned OFS_PC     = OFS_INS + XLEN;          // pc sits on top

    // full record width follows from the fields
    localparam int unsigned REC_W = OFS_PC + XLEN;

    typedef logic [REC_W-1:0] trace_rec_t;

    ////////////////////////////////////////////////////////////
    // buffer and credit sizing
    ////////////////////////////////////////////////////////////

    localparam int unsigned FIFO_DEPTH = 8;  // records
    localparam int unsigned FIFO_AW    = 3;  // pointer width, log2 depth

    // receiver grants this many credits after reset
    localparam int unsigned CREDITS = 4;
    localparam int unsigned CRD_W   = 3;     // counter width, must hold CREDITS

endpackage
